//--- design/adc_pkg.sv
package adc_pkg;

    // Width of one ADC sample
    // The top level passes this value down as a module parameter
    localparam int DATA_WIDTH = 16;

    // Channel tag width and the channel count that follows from it
    localparam int CHANNEL_BITS = 2;
    localparam int N_CHANNELS = 1 << CHANNEL_BITS;

    // One beat of a sample stream
    // There is no ready, so a beat with valid high is always taken
    typedef struct packed {
        logic                         valid;
        logic [CHANNEL_BITS-1:0]      dest;
        logic signed [DATA_WIDTH-1:0] data;
    } adc_sample_t;

    // Outputs of one window comparator
    typedef struct packed {
        logic trip_high;
        logic trip_low;
    } cmp_flags_t;

    // Threshold set of one comparator
    // In latching mode only low_falling and high_rising matter
    typedef struct packed {
        logic signed [DATA_WIDTH-1:0] low_falling;
        logic signed [DATA_WIDTH-1:0] low_rising;
        logic signed [DATA_WIDTH-1:0] high_falling;
        logic signed [DATA_WIDTH-1:0] high_rising;
    } cmp_thresholds_t;

    // Threshold registers carry the fast half low and the slow half high
    typedef struct packed {
        logic signed [15:0] slow;
        logic signed [15:0] fast;
    } reg_thr_t;

    // Layout of the control register
    typedef struct packed {
        logic [7:0] decimation;
        logic [5:0] reserved_hi;
        logic       fault_disable;
        logic       clear_fault;
        logic [7:0] fault_delay;
        logic [2:0] cal_shift;
        logic [1:0] clear_latch;
        logic [1:0] latch_mode;
        logic       reserved_lo;
    } reg_ctrl_t;

    // Layout of the calibration coefficient register
    typedef struct packed {
        logic signed [15:0] offset;
        logic [13:0]        reserved;
        logic [1:0]         channel;
    } reg_cal_t;

    // A register write word is read through the view that its address selects
    typedef union packed {
        reg_thr_t  thr;
        reg_ctrl_t ctrl;
        reg_cal_t  cal;
    } adc_reg_word_u;

    // Word addresses of the register map
    localparam logic [2:0] REG_CMP_LOW_F  = 3'd0;
    localparam logic [2:0] REG_CMP_LOW_R  = 3'd1;
    localparam logic [2:0] REG_CMP_HIGH_F = 3'd2;
    localparam logic [2:0] REG_CMP_HIGH_R = 3'd3;
    localparam logic [2:0] REG_CAL_COEFF  = 3'd4;
    localparam logic [2:0] REG_CONTROL    = 3'd5;

endpackage

//--- design/adc_control_regs.sv
`timescale 1ns/1ps

module adc_control_regs #(
    parameter int DATA_WIDTH = adc_pkg::DATA_WIDTH
) (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         reg_write,
    input  logic [2:0]                   reg_addr,
    input  adc_pkg::adc_reg_word_u       reg_wdata,
    output adc_pkg::cmp_thresholds_t     fast_thr,
    output adc_pkg::cmp_thresholds_t     slow_thr,
    output logic signed [DATA_WIDTH-1:0] offsets [adc_pkg::N_CHANNELS],
    output logic [2:0]                   cal_shift,
    output logic [1:0]                   latch_mode,
    output logic [1:0]                   clear_latch,
    output logic [7:0]                   fault_delay,
    output logic                         clear_fault,
    output logic                         fault_disable,
    output logic [7:0]                   decimation
);

    // All settings are plain registers, so a write shows on the outputs
    // one cycle after the strobe
    // clear_latch and clear_fault are ordinary bits here and stay asserted
    // until software writes them back to zero
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            fast_thr      <= '0;
            slow_thr      <= '0;
            for (int i = 0; i < adc_pkg::N_CHANNELS; i++) begin
                offsets[i] <= '0;
            end
            cal_shift     <= '0;
            latch_mode    <= '0;
            clear_latch   <= '0;
            fault_delay   <= '0;
            clear_fault   <= 1'b0;
            fault_disable <= 1'b0;
            // A ratio of one passes every sample straight through
            decimation    <= 8'd1;
        end else if (reg_write) begin
            case (reg_addr)
                // Each threshold word updates the same field in both sets
                adc_pkg::REG_CMP_LOW_F: begin
                    fast_thr.low_falling <= reg_wdata.thr.fast;
                    slow_thr.low_falling <= reg_wdata.thr.slow;
                end
                adc_pkg::REG_CMP_LOW_R: begin
                    fast_thr.low_rising <= reg_wdata.thr.fast;
                    slow_thr.low_rising <= reg_wdata.thr.slow;
                end
                adc_pkg::REG_CMP_HIGH_F: begin
                    fast_thr.high_falling <= reg_wdata.thr.fast;
                    slow_thr.high_falling <= reg_wdata.thr.slow;
                end
                adc_pkg::REG_CMP_HIGH_R: begin
                    fast_thr.high_rising <= reg_wdata.thr.fast;
                    slow_thr.high_rising <= reg_wdata.thr.slow;
                end
                // The channel field picks which offset is loaded
                adc_pkg::REG_CAL_COEFF: begin
                    offsets[reg_wdata.cal.channel] <= reg_wdata.cal.offset;
                end
                // The control word rewrites every setting at once
                adc_pkg::REG_CONTROL: begin
                    latch_mode    <= reg_wdata.ctrl.latch_mode;
                    clear_latch   <= reg_wdata.ctrl.clear_latch;
                    cal_shift     <= reg_wdata.ctrl.cal_shift;
                    fault_delay   <= reg_wdata.ctrl.fault_delay;
                    clear_fault   <= reg_wdata.ctrl.clear_fault;
                    fault_disable <= reg_wdata.ctrl.fault_disable;
                    decimation    <= reg_wdata.ctrl.decimation;
                end
                // Writes outside the map are dropped
                default: begin
                end
            endcase
        end
    end

    // Software must only address words that exist in the map
    a_addr_in_map: assert property (
        @(posedge clock) disable iff (!rst_n)
        reg_write |-> (reg_addr <= adc_pkg::REG_CONTROL)
    );

endmodule

//--- design/adc_calibration.sv
`timescale 1ns/1ps

module adc_calibration #(
    parameter int DATA_WIDTH = adc_pkg::DATA_WIDTH
) (
    input  logic                         clock,
    input  logic                         rst_n,
    input  adc_pkg::adc_sample_t         sample_in,
    input  logic signed [DATA_WIDTH-1:0] offsets [adc_pkg::N_CHANNELS],
    input  logic [2:0]                   cal_shift,
    output adc_pkg::adc_sample_t         fast_out
);

    // Saturation limits of a signed sample
    localparam logic signed [DATA_WIDTH-1:0] SAT_MAX = {1'b0, {(DATA_WIDTH-1){1'b1}}};
    localparam logic signed [DATA_WIDTH-1:0] SAT_MIN = {1'b1, {(DATA_WIDTH-1){1'b0}}};

    logic signed [DATA_WIDTH:0]   sum_full;
    logic signed [DATA_WIDTH-1:0] sum_sat;
    logic signed [DATA_WIDTH-1:0] cal_data;
    logic                         overflow;

    // One extra bit holds the full sum of sample and channel offset
    assign sum_full = sample_in.data + offsets[sample_in.dest];

    // The two top bits differ only when the sum left the sample range
    assign overflow = sum_full[DATA_WIDTH] ^ sum_full[DATA_WIDTH-1];

    // The sign bit of the wide sum tells which rail was crossed
    assign sum_sat = overflow ? (sum_full[DATA_WIDTH] ? SAT_MIN : SAT_MAX)
                              : sum_full[DATA_WIDTH-1:0];

    // Gain is a power-of-two attenuation that keeps the sign
    assign cal_data = sum_sat >>> cal_shift;

    // Tag and data follow the input after exactly one register stage
    always_ff @(posedge clock) begin
        fast_out.dest <= sample_in.dest;
        fast_out.data <= cal_data;
        if (!rst_n) begin
            fast_out.valid <= 1'b0;
        end else begin
            fast_out.valid <= sample_in.valid;
        end
    end

    // Calibration never drops or invents a sample
    a_valid_follows: assert property (
        @(posedge clock) disable iff (!rst_n)
        1'b1 |=> (fast_out.valid == $past(sample_in.valid))
    );

endmodule

//--- design/adc_window_comparator.sv
`timescale 1ns/1ps

module adc_window_comparator #(
    parameter int DATA_WIDTH = adc_pkg::DATA_WIDTH
) (
    input  logic                     clock,
    input  logic                     rst_n,
    input  adc_pkg::adc_sample_t     sample_in,
    input  adc_pkg::cmp_thresholds_t thresholds,
    input  logic                     latching,
    input  logic                     clear_latch,
    output adc_pkg::cmp_flags_t      flags
);

    logic signed [DATA_WIDTH-1:0] data;
    logic                         clear_active;
    logic                         above_high_rising;
    logic                         below_high_falling;
    logic                         below_low_falling;
    logic                         above_low_rising;
    adc_pkg::cmp_flags_t          next_flags;

    assign data = sample_in.data;

    // The clear bit only has meaning while the comparator latches
    assign clear_active = latching && clear_latch;

    // Signed compares against the four window edges
    assign above_high_rising  = data > thresholds.high_rising;
    assign below_high_falling = data < thresholds.high_falling;
    assign below_low_falling  = data < thresholds.low_falling;
    assign above_low_rising   = data > thresholds.low_rising;

    // Set wins over release on the same sample
    // In latching mode the release path is blocked and only a clear resets a flag
    always_comb begin
        next_flags = flags;
        if (sample_in.valid) begin
            if (above_high_rising) begin
                next_flags.trip_high = 1'b1;
            end else if (below_high_falling && !latching) begin
                next_flags.trip_high = 1'b0;
            end
            if (below_low_falling) begin
                next_flags.trip_low = 1'b1;
            end else if (above_low_rising && !latching) begin
                next_flags.trip_low = 1'b0;
            end
        end
    end

    // A held clear keeps both flags down even if the data is still outside
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (clear_active) begin
            flags <= '0;
        end else begin
            flags <= next_flags;
        end
    end

    // Without a sample or a clear the flags must not move
    a_flags_hold: assert property (
        @(posedge clock) disable iff (!rst_n)
        (!sample_in.valid && !clear_active) |=> $stable(flags)
    );

endmodule

//--- design/adc_decimator.sv
`timescale 1ns/1ps

module adc_decimator (
    input  logic                 clock,
    input  logic                 rst_n,
    input  adc_pkg::adc_sample_t sample_in,
    input  logic [7:0]           decimation,
    output adc_pkg::adc_sample_t sample_out
);

    logic [7:0] count [adc_pkg::N_CHANNELS];
    logic [7:0] ratio_q;
    logic [7:0] eff_ratio;
    logic [7:0] last_index;
    logic       ratio_changed;
    logic       keep;

    // Zero would stall the stream, so it is read as one
    assign eff_ratio  = (decimation == 8'd0) ? 8'd1 : decimation;
    assign last_index = eff_ratio - 8'd1;

    // A new ratio restarts every channel from a clean phase
    assign ratio_changed = decimation != ratio_q;

    // The greater-or-equal compare also covers a counter left over from a larger ratio
    assign keep = sample_in.valid && (count[sample_in.dest] >= last_index);

    // Each channel counts its own samples, so interleaving does not matter
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ratio_q <= 8'd1;
            for (int i = 0; i < adc_pkg::N_CHANNELS; i++) begin
                count[i] <= '0;
            end
        end else begin
            ratio_q <= decimation;
            if (ratio_changed) begin
                for (int i = 0; i < adc_pkg::N_CHANNELS; i++) begin
                    count[i] <= '0;
                end
            end else if (sample_in.valid) begin
                if (keep) begin
                    count[sample_in.dest] <= '0;
                end else begin
                    count[sample_in.dest] <= count[sample_in.dest] + 8'd1;
                end
            end
        end
    end

    // Kept samples leave one cycle later; dropped ones never raise valid
    always_ff @(posedge clock) begin
        sample_out.dest <= sample_in.dest;
        sample_out.data <= sample_in.data;
        if (!rst_n) begin
            sample_out.valid <= 1'b0;
        end else begin
            sample_out.valid <= keep;
        end
    end

    // Once the ratio is settled no channel counter may reach it
    for (genvar i = 0; i < adc_pkg::N_CHANNELS; i++) begin : g_count_chk
        a_count_range: assert property (
            @(posedge clock) disable iff (!rst_n)
            !ratio_changed |-> (count[i] < eff_ratio)
        );
    end

endmodule

//--- design/adc_fault_monitor.sv
`timescale 1ns/1ps

module adc_fault_monitor #(
    parameter int STICKY_FAULT = 0
) (
    input  logic                clock,
    input  logic                rst_n,
    input  adc_pkg::cmp_flags_t flags,
    input  logic [7:0]          fault_delay,
    input  logic                clear_fault,
    input  logic                fault_disable,
    output logic                fault
);

    logic [7:0] trip_count;
    logic       tripped;
    logic       set_fault;

    // Either side of the slow window counts as a trip
    assign tripped = flags.trip_high || flags.trip_low;

    // Greater-or-equal lets a fault appear once disable is released mid-trip
    assign set_fault = tripped && (trip_count >= fault_delay) && !fault_disable;

    // Consecutive trip cycles, saturating so a long trip cannot wrap to zero
    always_ff @(posedge clock) begin
        if (!rst_n || !tripped) begin
            trip_count <= '0;
        end else if (trip_count != 8'hff) begin
            trip_count <= trip_count + 8'd1;
        end
    end

    // Sticky mode keeps the fault until software clears it
    // otherwise the fault simply tracks the set condition
    always_ff @(posedge clock) begin
        if (!rst_n || clear_fault) begin
            fault <= 1'b0;
        end else if (STICKY_FAULT != 0) begin
            fault <= fault || set_fault;
        end else begin
            fault <= set_fault;
        end
    end

    // A disabled monitor never raises a new fault
    a_no_fault_when_disabled: assert property (
        @(posedge clock) disable iff (!rst_n)
        fault_disable |=> !$rose(fault)
    );

endmodule

//--- design/adc_post_processing.sv
`timescale 1ns/1ps

module adc_post_processing #(
    parameter int DATA_WIDTH   = adc_pkg::DATA_WIDTH,
    parameter int STICKY_FAULT = 0
) (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   reg_write,
    input  logic [2:0]             reg_addr,
    input  adc_pkg::adc_reg_word_u reg_wdata,
    input  adc_pkg::adc_sample_t   sample_in,
    output adc_pkg::adc_sample_t   fast_out,
    output adc_pkg::adc_sample_t   filtered_out,
    output adc_pkg::cmp_flags_t    fast_flags,
    output adc_pkg::cmp_flags_t    slow_flags,
    output logic                   fault
);

    // Settings from the register block
    adc_pkg::cmp_thresholds_t     fast_thr;
    adc_pkg::cmp_thresholds_t     slow_thr;
    logic signed [DATA_WIDTH-1:0] offsets [adc_pkg::N_CHANNELS];
    logic [2:0]                   cal_shift;
    logic [1:0]                   latch_mode;
    logic [1:0]                   clear_latch;
    logic [7:0]                   fault_delay;
    logic                         clear_fault;
    logic                         fault_disable;
    logic [7:0]                   decimation;

    adc_control_regs #(
        .DATA_WIDTH(DATA_WIDTH)
    ) regs (
        .clock(clock), .rst_n(rst_n),
        .reg_write(reg_write), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .fast_thr(fast_thr), .slow_thr(slow_thr), .offsets(offsets),
        .cal_shift(cal_shift), .latch_mode(latch_mode), .clear_latch(clear_latch),
        .fault_delay(fault_delay), .clear_fault(clear_fault),
        .fault_disable(fault_disable), .decimation(decimation)
    );

    // The fast comparator watches raw samples; bit 0 of each mode pair is its own
    adc_window_comparator #(
        .DATA_WIDTH(DATA_WIDTH)
    ) fast_cmp (
        .clock(clock), .rst_n(rst_n), .sample_in(sample_in), .thresholds(fast_thr),
        .latching(latch_mode[0]), .clear_latch(clear_latch[0]), .flags(fast_flags)
    );

    adc_calibration #(
        .DATA_WIDTH(DATA_WIDTH)
    ) calibration (
        .clock(clock), .rst_n(rst_n), .sample_in(sample_in),
        .offsets(offsets), .cal_shift(cal_shift), .fast_out(fast_out)
    );

    // Calibrated stream thinned per channel into the filtered stream
    adc_decimator decimator (
        .clock(clock), .rst_n(rst_n), .sample_in(fast_out),
        .decimation(decimation), .sample_out(filtered_out)
    );

    adc_window_comparator #(
        .DATA_WIDTH(DATA_WIDTH)
    ) slow_cmp (
        .clock(clock), .rst_n(rst_n), .sample_in(filtered_out), .thresholds(slow_thr),
        .latching(latch_mode[1]), .clear_latch(clear_latch[1]), .flags(slow_flags)
    );

    // Only the slow flags can raise a fault
    adc_fault_monitor #(
        .STICKY_FAULT(STICKY_FAULT)
    ) fault_monitor (
        .clock(clock), .rst_n(rst_n), .flags(slow_flags), .fault_delay(fault_delay),
        .clear_fault(clear_fault), .fault_disable(fault_disable), .fault(fault)
    );

endmodule

//--- verification/adc_post_processing_tb.sv
`timescale 1ns/1ps

module adc_post_processing_tb;

    localparam int FAULT_TIMEOUT = 40;
    localparam int SAMPLE_MAX = (1 << (adc_pkg::DATA_WIDTH - 1)) - 1;
    localparam int SAMPLE_MIN = -(1 << (adc_pkg::DATA_WIDTH - 1));

    logic                   clock;
    logic                   rst_n;
    logic                   reg_write;
    logic [2:0]             reg_addr;
    adc_pkg::adc_reg_word_u reg_wdata;
    adc_pkg::adc_sample_t   sample_in;
    adc_pkg::adc_sample_t   fast_out;
    adc_pkg::adc_sample_t   filtered_out;
    adc_pkg::cmp_flags_t    fast_flags;
    adc_pkg::cmp_flags_t    slow_flags;
    logic                   fault;

    // Expectations for the cycle in flight and the samples the decimator must keep
    adc_pkg::adc_sample_t   exp_fast;
    adc_pkg::cmp_flags_t    exp_fast_flags;
    logic                   flags_due;
    adc_pkg::adc_sample_t   kept_q [$];

    // Mirror of the calibration settings, used to predict the random fillers
    logic signed [15:0]     model_offset [adc_pkg::N_CHANNELS];
    logic [2:0]             model_shift;
    integer                 seed;
    integer                 fd;

    adc_post_processing #(
        .DATA_WIDTH(adc_pkg::DATA_WIDTH),
        .STICKY_FAULT(1)
    ) UUT (
        .clock(clock), .rst_n(rst_n),
        .reg_write(reg_write), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .sample_in(sample_in), .fast_out(fast_out), .filtered_out(filtered_out),
        .fast_flags(fast_flags), .slow_flags(slow_flags), .fault(fault)
    );

    always #4 clock = ~clock;

    task automatic end_in_failure;
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_and_end(input string reason);
        $display("%s", reason);
        end_in_failure();
    endtask

    task automatic need_fields(input int got, input int want);
        if (got != want) begin
            report_and_end("a line in the stimulus file has missing or bad fields");
        end
    endtask

    // Dest and data only matter when a beat is expected
    task automatic check_sample(input string name, input adc_pkg::adc_sample_t got,
                                input adc_pkg::adc_sample_t exp);
        if (got.valid !== exp.valid ||
            (exp.valid && (got.dest !== exp.dest || got.data !== exp.data))) begin
            $display("[ERROR] %s valid/dest/data got %h/%h/%h expected %h/%h/%h", name,
                     got.valid, got.dest, got.data, exp.valid, exp.dest, exp.data);
            end_in_failure();
        end
    endtask

    task automatic check_flags(input string name, input adc_pkg::cmp_flags_t got,
                               input adc_pkg::cmp_flags_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            end_in_failure();
        end
    endtask

    task automatic check_fault(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            end_in_failure();
        end
    endtask

    // Saturate to the sample range, then an arithmetic shift keeps the sign
    function automatic logic [15:0] predict_cal(input logic signed [15:0] raw,
                                                input logic signed [15:0] offset,
                                                input logic [2:0] shift);
        int sum;
        sum = int'(raw) + int'(offset);
        if (sum > SAMPLE_MAX) begin
            sum = SAMPLE_MAX;
        end else if (sum < SAMPLE_MIN) begin
            sum = SAMPLE_MIN;
        end
        sum = sum >>> shift;
        return sum[15:0];
    endfunction

    // Order is only kept within a channel, so take the oldest entry with the same tag
    task automatic match_filtered;
        adc_pkg::adc_sample_t candidate;
        int idx;
        idx = -1;
        for (int i = 0; i < kept_q.size(); i++) begin
            candidate = kept_q[i];
            if (idx < 0 && candidate.dest == filtered_out.dest) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            report_and_end("filtered_out carried a sample that the decimator should have dropped");
        end
        check_sample("filtered_out", filtered_out, kept_q[idx]);
        kept_q.delete(idx);
    endtask

    // Outputs are read on the falling edge, half a cycle after they settled
    task automatic next_cycle;
        @(negedge clock);
        check_sample("fast_out", fast_out, exp_fast);
        if (flags_due) begin
            check_flags("fast_flags", fast_flags, exp_fast_flags);
        end
        if (filtered_out.valid) begin
            match_filtered();
        end
        exp_fast = '0;
        flags_due = 1'b0;
        reg_write = 1'b0;
        sample_in = '0;
    endtask

    task automatic drive_sample(input logic [1:0] ch, input logic [15:0] data,
                                input logic [15:0] expect_data, input logic [1:0] flags,
                                input logic kept);
        adc_pkg::adc_sample_t expected;
        expected.valid = 1'b1;
        expected.dest = ch;
        expected.data = expect_data;
        sample_in.valid = 1'b1;
        sample_in.dest = ch;
        sample_in.data = data;
        exp_fast = expected;
        exp_fast_flags = flags;
        flags_due = 1'b1;
        if (kept) begin
            kept_q.push_back(expected);
        end
        next_cycle();
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [31:0] word);
        adc_pkg::adc_reg_word_u decoded;
        decoded = word;
        reg_write = 1'b1;
        reg_addr = addr;
        reg_wdata = decoded;
        if (addr == adc_pkg::REG_CAL_COEFF) begin
            model_offset[decoded.cal.channel] = decoded.cal.offset;
        end
        if (addr == adc_pkg::REG_CONTROL) begin
            model_shift = decoded.ctrl.cal_shift;
        end
        next_cycle();
    endtask

    task automatic wait_fault(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (fault !== level) begin
            if (cycles >= FAULT_TIMEOUT) begin
                report_and_end($sformatf("fault never %s within %0d cycles", what, FAULT_TIMEOUT));
            end
            next_cycle();
            cycles++;
        end
    endtask

    initial begin : run_stim
        logic [7:0]      cmd;
        logic [31:0]     word;
        logic [15:0]     data;
        logic [15:0]     expect_data;
        logic [2:0]      addr;
        logic [1:0]      ch;
        logic [1:0]      flags;
        logic            kept;
        integer          count;
        integer          fields;
        integer          rnd;
        logic [8*96-1:0] rest;
        logic            at_end;
        clock = 1'b0;
        rst_n = 1'b0;
        reg_write = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        sample_in = '0;
        exp_fast = '0;
        exp_fast_flags = '0;
        flags_due = 1'b0;
        model_shift = '0;
        for (int i = 0; i < adc_pkg::N_CHANNELS; i++) begin
            model_offset[i] = '0;
        end
        seed = 32'h688d_b755;
        at_end = 1'b0;
        fd = $fopen("verification/adc_stim.txt", "r");
        if (fd == 0) begin
            report_and_end("could not open verification/adc_stim.txt");
        end
        repeat (3) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        while (!at_end) begin
            fields = $fscanf(fd, " %c", cmd);
            if (fields != 1) begin
                at_end = 1'b1;
            end else begin
                case (cmd)
                    "#": fields = $fgets(rest, fd);
                    "W": begin
                        fields = $fscanf(fd, "%h %h", addr, word);
                        need_fields(fields, 2);
                        write_reg(addr, word);
                    end
                    "S": begin
                        fields = $fscanf(fd, "%h %h %h %h %h", ch, data, expect_data, flags, kept);
                        need_fields(fields, 5);
                        drive_sample(ch, data, expect_data, flags, kept);
                    end
                    // Random fillers stay high enough to keep both comparators tripped high
                    "R": begin
                        fields = $fscanf(fd, "%d %h %h", count, flags, kept);
                        need_fields(fields, 3);
                        repeat (count) begin
                            rnd = $random(seed);
                            ch = rnd[1:0];
                            rnd = $random(seed);
                            data = {4'h5, rnd[11:0]};
                            expect_data = predict_cal(data, model_offset[ch], model_shift);
                            drive_sample(ch, data, expect_data, flags, kept);
                        end
                    end
                    "N": begin
                        fields = $fscanf(fd, "%d", count);
                        need_fields(fields, 1);
                        repeat (count) next_cycle();
                    end
                    "L": begin
                        fields = $fscanf(fd, "%h", flags);
                        need_fields(fields, 1);
                        check_flags("slow_flags", slow_flags, flags);
                    end
                    "K": begin
                        fields = $fscanf(fd, "%h", kept);
                        need_fields(fields, 1);
                        check_fault("fault", fault, kept);
                    end
                    "U": wait_fault(1'b1, "rose");
                    "D": wait_fault(1'b0, "cleared");
                    default: report_and_end("unknown command letter in the stimulus file");
                endcase
            end
        end
        $fclose(fd);
        repeat (4) next_cycle();
        if (kept_q.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            report_and_end($sformatf("%0d kept samples never reached filtered_out", kept_q.size()));
        end
    end

endmodule

//--- verification/adc_stim.txt
# W addr word | S ch raw cal fast_flags kept | R count fast_flags kept | N idle cycles
# L slow_flags | K fault | U wait fault high | D wait fault low (all values hex, counts decimal)
K 0
L 0
W 0 8000FC18
W 1 8000FCE0
W 2 7FFF0320
W 3 7FFF03E8
W 4 00640000
W 4 FFCE0001
W 4 70000002
W 4 FF380003
# Calibration with shift 1, no decimation
W 5 01000020
N 2
S 0 0100 00B2 0 1
S 1 0010 FFEF 0 1
S 2 2000 3FFF 2 1
S 3 FF00 FF1C 0 1
S 3 8010 C000 1 1
S 0 0000 0032 0 1
S 1 FFFF FFE6 0 1
N 3
# Decimation by 3
W 5 03000000
N 2
S 0 0001 0065 0 0
S 1 0002 FFD0 0 0
S 0 0003 0067 0 0
S 0 0004 0068 0 1
S 1 0005 FFD3 0 0
S 1 0006 FFD4 0 1
S 0 0008 006C 0 0
S 0 000B 006F 0 0
S 0 000C 0070 0 1
N 3
# Fast comparator hysteresis ramp
W 5 01000000
N 2
S 0 0000 0064 0 1
S 0 03E8 044C 0 1
S 0 03E9 044D 2 1
S 0 0320 0384 2 1
S 0 031F 0383 0 1
S 0 FC18 FC7C 0 1
S 0 FC17 FC7B 1 1
S 0 FCE0 FD44 1 1
S 0 FCE1 FD45 0 1
# Latching mode on the fast comparator
W 5 01000002
N 2
S 1 07D0 079E 2 1
S 1 0000 FFCE 2 1
S 1 F830 F7FE 3 1
S 1 0000 FFCE 3 1
W 5 0100000A
N 2
S 1 0000 FFCE 0 1
W 5 01000002
N 2
S 1 0000 FFCE 0 1
S 1 07D0 079E 2 1
W 5 01000000
N 2
S 1 0000 FFCE 0 1
N 3
K 0
L 0
# Sticky fault with delay 4, then the same trip with the fault disabled
W 2 10000320
W 3 200003E8
W 5 01000400
N 2
R 8 2 1
U
N 4
L 2
S 0 0000 0064 0 1
N 3
L 0
K 1
W 5 01010400
D
W 5 01000400
N 2
K 0
W 5 01020400
N 2
R 8 2 1
N 10
L 2
K 0
S 0 0000 0064 0 1
N 3
L 0
K 0

//--- src.f
design/adc_pkg.sv
design/adc_control_regs.sv
design/adc_calibration.sv
design/adc_window_comparator.sv
design/adc_decimator.sv
design/adc_fault_monitor.sv
design/adc_post_processing.sv
verification/adc_post_processing_tb.sv

//--- Bender.yml
package:
  name: adc_post_processing

sources:
  - files:
      - design/adc_pkg.sv
      - design/adc_control_regs.sv
      - design/adc_calibration.sv
      - design/adc_window_comparator.sv
      - design/adc_decimator.sv
      - design/adc_fault_monitor.sv
      - design/adc_post_processing.sv
  - target: simulation
    files:
      - verification/adc_post_processing_tb.sv
